// File: rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // 2 ways x 64 sets x 16 words = 8 KB
    localparam int WAYS = 2;
    localparam int SETS = 64;
    localparam int LINE_WORDS = 16;

    localparam int ALIGN_BITS = 2;
    localparam int OFFSET_BITS = 4;
    localparam int INDEX_BITS = 6;
    localparam int WAY_BITS = 1;
    localparam int TAG_BITS = 20;

    // address fields, high to low: tag, index, offset, align
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [WAY_BITS-1:0] way_t;

    // data array address {way, index, offset}
    typedef logic [WAY_BITS+INDEX_BITS+OFFSET_BITS-1:0] data_addr_t;

    typedef enum logic [1:0] {
        REFILL_IDLE,
        REFILL_FILL,
        REFILL_DONE
    } refill_state_t;

endpackage

`default_nettype wire

// File: rtl/icache_lookup.sv
`timescale 1ns/100ps
`default_nettype none

module icache_lookup
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  req_valid,
    input  addr_t req_addr,
    input  logic  fill_done,
    output logic  addr_ok,
    output logic  s2_ready,
    output logic  s2_miss,
    output way_t  s2_way,
    output addr_t s2_addr
);

    tag_t                       tag_ram [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0]  valid;
    logic [SETS-1:0]            plru;

    tag_t            req_tag;
    index_t          req_index;
    logic [WAYS-1:0] hit_vec;
    logic            hit;
    way_t            hit_way;
    way_t            victim;
    way_t            sel_way;
    logic            accept;

    assign req_tag   = req_addr[ADDR_W-1 -: TAG_BITS];
    assign req_index = req_addr[ALIGN_BITS+OFFSET_BITS +: INDEX_BITS];

    // tag compare in the accept cycle
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid[w][req_index] && (tag_ram[w][req_index] == req_tag);
            if (hit_vec[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit     = |hit_vec;
    assign victim  = plru[req_index];
    assign sel_way = hit ? hit_way : victim;

    // stall while the miss is outstanding
    assign addr_ok = !s2_miss;
    assign accept  = req_valid && addr_ok;

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid <= '0;
            plru  <= '0;
        end else if (accept) begin
            // point at the way not just used
            plru[req_index] <= ~sel_way;
            if (!hit) begin
                valid[sel_way][req_index] <= 1'b1;
            end
        end
    end

    // claim the victim at the accept edge
    always_ff @(posedge clk) begin
        if (accept && !hit) begin
            tag_ram[sel_way][req_index] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            s2_ready <= 1'b0;
            s2_miss  <= 1'b0;
        end else if (s2_miss) begin
            s2_ready <= fill_done;
            if (fill_done) begin
                s2_miss <= 1'b0;
            end
        end else begin
            s2_ready <= accept && hit;
            s2_miss  <= accept && !hit;
        end
    end

    // stage 2 payload held during a miss
    always_ff @(posedge clk) begin
        if (accept) begin
            s2_addr <= req_addr;
            s2_way  <= sel_way;
        end
    end

    a_one_hit: assert property (
        @(posedge clk) disable iff (resetn)
        accept |-> $onehot0(hit_vec)
    );

endmodule

`default_nettype wire

// File: rtl/icache_refill.sv
`timescale 1ns/100ps
`default_nettype none

module icache_refill
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       s2_miss,
    input  way_t       s2_way,
    input  addr_t      s2_addr,
    input  logic       mem_ready,
    input  logic       mem_last,
    input  word_t      mem_rdata,
    output logic       mem_req,
    output addr_t      mem_addr,
    output logic       wr_en,
    output data_addr_t wr_addr,
    output word_t      wr_data,
    output logic       fill_done
);

    refill_state_t state;
    offset_t       beat;
    index_t        miss_index;

    assign miss_index = s2_addr[ALIGN_BITS+OFFSET_BITS +: INDEX_BITS];

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= REFILL_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                REFILL_IDLE: begin
                    beat <= '0;
                    if (s2_miss) begin
                        state <= REFILL_FILL;
                    end
                end
                REFILL_FILL: begin
                    if (mem_ready) begin
                        beat <= beat + 1'b1;
                        if (mem_last) begin
                            state <= REFILL_DONE;
                        end
                    end
                end
                REFILL_DONE: begin
                    state <= REFILL_IDLE;
                end
                default: begin
                    state <= REFILL_IDLE;
                end
            endcase
        end
    end

    // line address, stable since stage 2 is stalled
    assign mem_req  = (state == REFILL_FILL);
    assign mem_addr = {s2_addr[ADDR_W-1:ALIGN_BITS+OFFSET_BITS],
                       {(ALIGN_BITS+OFFSET_BITS){1'b0}}};

    // one word per beat into the victim way
    assign wr_en     = mem_req && mem_ready;
    assign wr_addr   = {s2_way, miss_index, beat};
    assign wr_data   = mem_rdata;
    assign fill_done = (state == REFILL_DONE);

    a_req_held: assert property (
        @(posedge clk) disable iff (resetn)
        mem_req && !(mem_ready && mem_last) |=> mem_req && $stable(mem_addr)
    );

    a_last_beat: assert property (
        @(posedge clk) disable iff (resetn)
        wr_en && mem_last |-> beat == offset_t'(LINE_WORDS - 1)
    );

endmodule

`default_nettype wire

// File: rtl/icache_data_stage.sv
`timescale 1ns/100ps
`default_nettype none

module icache_data_stage
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       s2_ready,
    input  way_t       s2_way,
    input  addr_t      s2_addr,
    input  logic       wr_en,
    input  data_addr_t wr_addr,
    input  word_t      wr_data,
    output logic       data_ok,
    output word_t      rdata
);

    word_t      data_ram [WAYS*SETS*LINE_WORDS];
    data_addr_t rd_addr;

    assign rd_addr = {s2_way,
                      s2_addr[ALIGN_BITS+OFFSET_BITS +: INDEX_BITS],
                      s2_addr[ALIGN_BITS +: OFFSET_BITS]};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_ram[wr_addr] <= wr_data;
        end
    end

    // registered read, one cycle behind s2_ready
    always_ff @(posedge clk) begin
        if (s2_ready) begin
            rdata <= data_ram[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= s2_ready;
        end
    end

    // refill and hit reads never share a cycle
    a_no_rw_clash: assert property (
        @(posedge clk) disable iff (resetn)
        !(wr_en && s2_ready)
    );

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  req_valid,
    input  addr_t req_addr,
    input  logic  mem_ready,
    input  logic  mem_last,
    input  word_t mem_rdata,
    output logic  addr_ok,
    output logic  data_ok,
    output word_t rdata,
    output logic  mem_req,
    output addr_t mem_addr
);

    logic       s2_ready;
    logic       s2_miss;
    way_t       s2_way;
    addr_t      s2_addr;
    logic       fill_done;
    logic       wr_en;
    data_addr_t wr_addr;
    word_t      wr_data;

    icache_lookup u_lookup (
        .clk       (clk),
        .resetn    (resetn),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .fill_done (fill_done),
        .addr_ok   (addr_ok),
        .s2_ready  (s2_ready),
        .s2_miss   (s2_miss),
        .s2_way    (s2_way),
        .s2_addr   (s2_addr)
    );

    // side path for misses
    icache_refill u_refill (
        .clk       (clk),
        .resetn    (resetn),
        .s2_miss   (s2_miss),
        .s2_way    (s2_way),
        .s2_addr   (s2_addr),
        .mem_ready (mem_ready),
        .mem_last  (mem_last),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .fill_done (fill_done)
    );

    icache_data_stage u_data_stage (
        .clk      (clk),
        .resetn   (resetn),
        .s2_ready (s2_ready),
        .s2_way   (s2_way),
        .s2_addr  (s2_addr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .data_ok  (data_ok),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 40 ns period
    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

// File: sim/icache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tb
    import icache_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY = 2;
    // six refills under 60 cycles each plus two line reads leave a wide margin
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int RNG_SEED = 72;
    localparam word_t MEM_KEY = 32'h5a5a_0000;

    logic  clk;
    logic  resetn;
    logic  req_valid;
    addr_t req_addr;
    logic  addr_ok;
    logic  data_ok;
    word_t rdata;
    logic  mem_req;
    addr_t mem_addr;
    logic  mem_ready;
    logic  mem_last;
    word_t mem_rdata;

    // memory model state
    int    burst_count = 0;
    int    beat_total = 0;
    int    stall_cycles = 0;
    int    beat_cnt = 0;
    logic  in_burst = 1'b0;
    logic  random_ready = 1'b0;
    addr_t burst_addr;
    addr_t last_burst_addr;

    // reference copy of tags, valid bits and PLRU bits
    tag_t  ref_tag [WAYS][SETS];
    logic  ref_valid [WAYS][SETS];
    logic  ref_plru [SETS];

    word_t resp_q [$];
    int    cycle_count = 0;

    tb_clock u_clock (
        .clk (clk)
    );

    icache_top DUT (
        .clk       (clk),
        .resetn    (resetn),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .mem_ready (mem_ready),
        .mem_last  (mem_last),
        .mem_rdata (mem_rdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr)
    );

    function automatic word_t mem_word(addr_t a);
        return a ^ MEM_KEY;
    endfunction

    function automatic addr_t make_addr(tag_t tag, index_t index, offset_t offset);
        return {tag, index, offset, 2'b00};
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got == exp) else begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // predicts hit or miss by the PLRU rule and updates the reference copy
    task automatic predict_access(input addr_t a, output logic hit);
        tag_t   tag;
        index_t index;
        way_t   way;
        tag = a[ADDR_W-1 -: TAG_BITS];
        index = a[ALIGN_BITS+OFFSET_BITS +: INDEX_BITS];
        hit = 1'b0;
        way = way_t'(ref_plru[index]);
        for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[w][index] && ref_tag[w][index] == tag) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        if (!hit) begin
            ref_tag[way][index] = tag;
            ref_valid[way][index] = 1'b1;
        end
        ref_plru[index] = ~way;
    endtask

    // holds the request until an edge with addr_ok high
    task automatic issue(input addr_t a);
        logic taken;
        taken = 1'b0;
        req_valid = 1'b1;
        req_addr = a;
        while (!taken) begin
            @(negedge clk);
            taken = addr_ok;
            next_cycle();
        end
    endtask

    task automatic wait_responses(input int n);
        while (resp_q.size() < n) begin
            next_cycle();
        end
        // one more cycle so a stray pulse shows up
        next_cycle();
        check_word("data_ok count", word_t'(resp_q.size()), word_t'(n));
    endtask

    task automatic fetch_check(input addr_t a);
        logic hit;
        int   bursts_before;
        predict_access(a, hit);
        bursts_before = burst_count;
        issue(a);
        req_valid = 1'b0;
        wait_responses(1);
        check_word("rdata", resp_q.pop_front(), mem_word(a));
        check_word("burst count", word_t'(burst_count - bursts_before), hit ? 32'd0 : 32'd1);
    endtask

    task automatic read_line_check(input addr_t base);
        logic hit;
        int   misses;
        int   bursts_before;
        int   start_cycle;
        misses = 0;
        bursts_before = burst_count;
        start_cycle = cycle_count;
        for (int w = 0; w < LINE_WORDS; w++) begin
            predict_access(base + addr_t'(w * 4), hit);
            if (!hit) begin
                misses++;
            end
            issue(base + addr_t'(w * 4));
        end
        req_valid = 1'b0;
        if (misses == 0) begin
            check_word("accept cycles", word_t'(cycle_count - start_cycle), word_t'(LINE_WORDS));
        end
        wait_responses(LINE_WORDS);
        for (int w = 0; w < LINE_WORDS; w++) begin
            check_word("rdata", resp_q.pop_front(), mem_word(base + addr_t'(w * 4)));
        end
        check_word("burst count", word_t'(burst_count - bursts_before), word_t'(misses));
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_word("addr_ok", word_t'(addr_ok), 32'd1);
        check_word("data_ok", word_t'(data_ok), 32'd0);
        check_word("mem_req", word_t'(mem_req), 32'd0);
        next_cycle();
    endtask

    task automatic test_cold_miss();
        int beats_before;
        beats_before = beat_total;
        fetch_check(make_addr(20'h00012, 6'd13, 4'd2));
        check_word("beats per burst", word_t'(beat_total - beats_before), word_t'(LINE_WORDS));
        check_word("mem_addr", last_burst_addr, make_addr(20'h00012, 6'd13, 4'd0));
    endtask

    task automatic test_back_to_back();
        read_line_check(make_addr(20'h00012, 6'd13, 4'd0));
    endtask

    // tags A, B, C share set 20
    task automatic test_plru();
        fetch_check(make_addr(20'h00100, 6'd20, 4'd1));
        fetch_check(make_addr(20'h00200, 6'd20, 4'd3));
        fetch_check(make_addr(20'h00100, 6'd20, 4'd5));
        fetch_check(make_addr(20'h00300, 6'd20, 4'd7));
        fetch_check(make_addr(20'h00100, 6'd20, 4'd9));
        fetch_check(make_addr(20'h00200, 6'd20, 4'd11));
    endtask

    task automatic test_back_pressure();
        int stalls_before;
        stalls_before = stall_cycles;
        random_ready = 1'b1;
        fetch_check(make_addr(20'h00007, 6'd40, 4'd9));
        random_ready = 1'b0;
        assert (stall_cycles > stalls_before) else begin
            $display("back-pressure test saw no cycle with mem_ready low during the burst");
            abort_run();
        end
        read_line_check(make_addr(20'h00007, 6'd40, 4'd0));
    endtask

    // memory model samples at the falling edge and drives after the rising edge
    initial begin : memory_model
        logic xfer;
        logic last;
        void'($urandom(RNG_SEED));
        mem_ready = 1'b0;
        mem_last = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            xfer = mem_req && mem_ready;
            last = xfer && mem_last;
            if (mem_req && !mem_ready) begin
                stall_cycles++;
            end
            if (mem_req && !in_burst) begin
                in_burst = 1'b1;
                burst_addr = mem_addr;
            end else if (mem_req) begin
                check_word("mem_addr", mem_addr, burst_addr);
            end
            next_cycle();
            if (xfer) begin
                beat_total++;
                beat_cnt++;
            end
            if (last) begin
                in_burst = 1'b0;
                beat_cnt = 0;
                burst_count++;
                last_burst_addr = burst_addr;
            end
            mem_ready = random_ready ? ($urandom() % 2 == 1) : 1'b1;
            mem_rdata = mem_word(mem_addr + addr_t'(beat_cnt * 4));
            mem_last = mem_req && (beat_cnt == LINE_WORDS - 1);
        end
    end

    always @(negedge clk) begin
        if (data_ok) begin
            resp_q.push_back(rdata);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        resetn = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        for (int s = 0; s < SETS; s++) begin
            ref_plru[s] = 1'b0;
            for (int w = 0; w < WAYS; w++) begin
                ref_valid[w][s] = 1'b0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b0;
        test_reset_state();
        test_cold_miss();
        test_back_to_back();
        test_plru();
        test_back_pressure();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: icache.f
rtl/icache_pkg.sv
rtl/icache_lookup.sv
rtl/icache_refill.sv
rtl/icache_data_stage.sv
rtl/icache_top.sv
sim/tb_clock.sv
sim/icache_tb.sv

// File: run.sh
#!/bin/sh
# builds the icache testbench with Verilator, runs it, and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f icache.f --top-module icache_tb \
    -o icache_sim && ./obj_dir/icache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
